/* common/tex_defs.svh */
`ifndef TEX_DEFS_SVH
`define TEX_DEFS_SVH

// Texels per bilinear quad.
`define TEX_NUM_TEXELS 4

// Bits in one unpacked color channel.
`define TEX_COLOR_BITS 8

// Channels per color, R G B A.
`define TEX_NUM_CHANNELS 4

// Width of the u and v blend fractions.
`define TEX_FRAC_BITS 8

// Width of the texture format code.
`define TEX_FORMAT_BITS 3

`endif

/* common/tex_pkg.sv */
`include "tex_defs.svh"

package tex_pkg;

    // Codes 6 and 7 unpack as R8G8B8A8.
    typedef enum logic [`TEX_FORMAT_BITS-1:0] {
        TEX_FORMAT_R8G8B8A8 = 3'd0,
        TEX_FORMAT_R5G6B5   = 3'd1,
        TEX_FORMAT_R4G4B4A4 = 3'd2,
        TEX_FORMAT_L8A8     = 3'd3,
        TEX_FORMAT_L8       = 3'd4,
        TEX_FORMAT_A8       = 3'd5
    } tex_format_e;

    typedef enum logic {
        POINT    = 1'b0,
        BILINEAR = 1'b1
    } tex_filter_e;

    // Sampler controller states.
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        UNPACK  = 2'd1,
        BLEND   = 2'd2,
        RESPOND = 2'd3
    } tex_state_e;

endpackage

/* common/tex_texel_if.sv */
`timescale 1ns/1ps
`include "tex_defs.svh"

interface tex_texel_if;

    // Each lerp texel holds channel c in bits 16c+7:16c, upper byte of each field zero.
    localparam int LERP_BITS = 2 * `TEX_COLOR_BITS * `TEX_NUM_CHANNELS;

    logic [`TEX_NUM_TEXELS-1:0][LERP_BITS-1:0]       lerp_texel;
    logic [`TEX_NUM_CHANNELS*`TEX_COLOR_BITS-1:0]    pt_texel;
    logic [`TEX_NUM_CHANNELS-1:0]                    color_enable;
    tex_pkg::tex_filter_e                            filter;
    logic [`TEX_FRAC_BITS-1:0]                       u;
    logic [`TEX_FRAC_BITS-1:0]                       v;

    modport fmt (output lerp_texel, pt_texel, color_enable, filter, u, v);
    modport lerp (input lerp_texel, pt_texel, u, v);

endinterface

/* design/tex_channel_counter.sv */
`timescale 1ns/1ps
`include "tex_defs.svh"

module tex_channel_counter (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         clear,
    input  logic                         step,
    input  logic [`TEX_NUM_CHANNELS-1:0] color_enable,
    output logic [1:0]                   chan,
    output logic                         chan_last
);

    logic [1:0] last_chan;

    // Enables are contiguous from bit 0, so the top set bit is the last channel.
    always_comb begin
        last_chan = '0;
        for (int c = 1; c < `TEX_NUM_CHANNELS; c++) begin
            if (color_enable[c]) begin
                last_chan = 2'(c);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            chan <= '0;
        end else if (clear) begin
            chan <= '0;
        end else if (step) begin
            chan <= chan + 2'd1;
        end
    end

    assign chan_last = (chan == last_chan);

endmodule

/* design/tex_sample_ctrl.sv */
`timescale 1ns/1ps

module tex_sample_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req,
    input  tex_pkg::tex_filter_e filter,
    input  logic                 chan_last,
    output logic                 load,
    output logic                 clear,
    output logic                 blend_en,
    output logic                 pt_store,
    output logic                 busy,
    output logic                 rsp_valid
);

    tex_pkg::tex_state_e state;
    tex_pkg::tex_state_e state_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= tex_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Point: IDLE, UNPACK, RESPOND.
    // Bilinear: IDLE, UNPACK, one BLEND per enabled channel, RESPOND.
    always_comb begin
        state_next = state;
        case (state)
            tex_pkg::IDLE: begin
                if (req) begin
                    state_next = tex_pkg::UNPACK;
                end
            end
            tex_pkg::UNPACK: begin
                if (filter == tex_pkg::BILINEAR) begin
                    state_next = tex_pkg::BLEND;
                end else begin
                    state_next = tex_pkg::RESPOND;
                end
            end
            tex_pkg::BLEND: begin
                if (chan_last) begin
                    state_next = tex_pkg::RESPOND;
                end
            end
            default: begin
                state_next = tex_pkg::IDLE;
            end
        endcase
    end

    // A request is taken only in IDLE, so a req while busy is dropped.
    assign load      = (state == tex_pkg::IDLE) && req;
    assign clear     = load;
    assign pt_store  = (state == tex_pkg::UNPACK) && (filter == tex_pkg::POINT);
    assign blend_en  = (state == tex_pkg::BLEND);
    assign busy      = (state != tex_pkg::IDLE);
    assign rsp_valid = (state == tex_pkg::RESPOND);

endmodule

/* design/tex_sampler.sv */
`timescale 1ns/1ps
`include "tex_defs.svh"

module tex_sampler (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         req,
    input  logic [`TEX_FORMAT_BITS-1:0]                  format,
    input  logic                                         filter,
    input  logic [`TEX_FRAC_BITS-1:0]                    u,
    input  logic [`TEX_FRAC_BITS-1:0]                    v,
    input  logic [`TEX_NUM_TEXELS-1:0][31:0]             texel_data,
    output logic                                         busy,
    output logic                                         rsp_valid,
    output logic [`TEX_NUM_CHANNELS*`TEX_COLOR_BITS-1:0] color
);

    logic       load;
    logic       clear;
    logic       blend_en;
    logic       pt_store;
    logic       chan_last;
    logic [1:0] chan;

    tex_texel_if texel_bus ();

    tex_format u_format (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load),
        .texel_data (texel_data),
        .format     (tex_pkg::tex_format_e'(format)),
        .filter_in  (tex_pkg::tex_filter_e'(filter)),
        .u_in       (u),
        .v_in       (v),
        .texels     (texel_bus.fmt)
    );

    tex_lerp u_lerp (
        .clk      (clk),
        .rst_n    (rst_n),
        .texels   (texel_bus.lerp),
        .blend_en (blend_en),
        .pt_store (pt_store),
        .clear    (clear),
        .chan     (chan),
        .color    (color)
    );

    // Restarts at channel 0 with every new request.
    tex_channel_counter u_counter (
        .clk          (clk),
        .rst_n        (rst_n),
        .clear        (load),
        .step         (blend_en),
        .color_enable (texel_bus.color_enable),
        .chan         (chan),
        .chan_last    (chan_last)
    );

    tex_sample_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .filter    (texel_bus.filter),
        .chan_last (chan_last),
        .load      (load),
        .clear     (clear),
        .blend_en  (blend_en),
        .pt_store  (pt_store),
        .busy      (busy),
        .rsp_valid (rsp_valid)
    );

endmodule

/* filelist.f */
+incdir+common
common/tex_pkg.sv
common/tex_texel_if.sv
tex_format/tex_format.sv
tex_lerp/tex_lerp.sv
design/tex_channel_counter.sv
design/tex_sample_ctrl.sv
design/tex_sampler.sv
tests/tex_sampler_props.sv
tests/tex_sampler_tb.sv

/* run.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tex_sampler_tb \
    -f filelist.f \
    -o Vtex_sampler_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtex_sampler_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit "$status"
fi

exit 0

/* tests/tex_sampler_props.sv */
`timescale 1ns/1ps

module tex_sampler_props (
    input logic                clk,
    input logic                rst_n,
    input tex_pkg::tex_state_e state,
    input logic                req,
    input logic                load,
    input logic                busy,
    input logic                blend_en,
    input logic                rsp_valid
);

    rsp_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |=> !rsp_valid)
        else $error("rsp_valid stayed high for more than one cycle");

    // Without a request the FSM stays in IDLE and busy stays low.
    idle_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        ((state == tex_pkg::IDLE) && !req) |=> !busy)
        else $error("busy rose in IDLE without a request");

    // Blending starts right after UNPACK and then runs without a gap.
    blend_only_in_blend: assert property (@(posedge clk) disable iff (!rst_n)
        blend_en |-> ($past(state == tex_pkg::UNPACK) || $past(blend_en)))
        else $error("blend_en outside the BLEND sequence");

    // A new quad must never overwrite the one being filtered.
    no_load_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (busy && !rsp_valid) |=> !load)
        else $error("load asserted while busy");

endmodule

bind tex_sample_ctrl tex_sampler_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .state     (state),
    .req       (req),
    .load      (load),
    .busy      (busy),
    .blend_en  (blend_en),
    .rsp_valid (rsp_valid)
);

/* tests/tex_sampler_tb.sv */
`timescale 1ns/1ps
`include "tex_defs.svh"

module tex_sampler_tb;

    localparam int RESPONSE_TIMEOUT = 20;

    logic                             clk;
    logic                             rst_n;
    logic                             req;
    logic [`TEX_FORMAT_BITS-1:0]      format;
    logic                             filter;
    logic [`TEX_FRAC_BITS-1:0]        u;
    logic [`TEX_FRAC_BITS-1:0]        v;
    logic [`TEX_NUM_TEXELS-1:0][31:0] texel_data;
    logic                             busy;
    logic                             rsp_valid;
    logic [31:0]                      color;
    logic [31:0]                      lcg_state;

    tex_sampler DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .format     (format),
        .filter     (filter),
        .u          (u),
        .v          (v),
        .texel_data (texel_data),
        .busy       (busy),
        .rsp_valid  (rsp_valid),
        .color      (color)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [`TEX_NUM_TEXELS-1:0][31:0] random_quad();
        logic [`TEX_NUM_TEXELS-1:0][31:0] quad;
        for (int i = 0; i < `TEX_NUM_TEXELS; i++) begin
            quad[i] = lcg_next();
        end
        return quad;
    endfunction

    // Channel c of the unpacked texel lands in byte c.
    function automatic logic [31:0] unpack_channels(input logic [31:0] t, input logic [2:0] fmt);
        logic [31:0] ch;
        case (fmt)
            3'd1:       ch = {8'h00, 3'b000, t[15:11], 2'b00, t[10:5], 3'b000, t[4:0]};
            3'd2:       ch = {4'h0, t[15:12], 4'h0, t[11:8], 4'h0, t[7:4], 4'h0, t[3:0]};
            3'd3:       ch = {16'h0000, t[15:8], t[7:0]};
            3'd4, 3'd5: ch = {24'h000000, t[7:0]};
            default:    ch = t;
        endcase
        return ch;
    endfunction

    function automatic logic [3:0] enable_mask(input logic [2:0] fmt);
        case (fmt)
            3'd1, 3'd2: return 4'b0111;
            3'd3:       return 4'b0011;
            3'd4, 3'd5: return 4'b0001;
            default:    return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] point_texel(input logic [31:0] t, input logic [2:0] fmt);
        logic [31:0] ch;
        ch = unpack_channels(t, fmt);
        if (fmt == 3'd1) begin
            return {ch[23:0], 8'hFF};
        end
        return ch;
    endfunction

    function automatic logic [7:0] lerp_ref(input logic [7:0] a, input logic [7:0] b,
                                            input logic [7:0] f);
        int sum;
        sum = int'(a) * (256 - int'(f)) + int'(b) * int'(f);
        return 8'(sum >> 8);
    endfunction

    function automatic logic [31:0] expected_bilinear(input logic [3:0][31:0] tx,
                                                      input logic [2:0] fmt,
                                                      input logic [7:0] uu,
                                                      input logic [7:0] vv);
        logic [3:0][31:0] ch;
        logic [3:0]       en;
        logic [31:0]      res;
        logic [7:0]       top;
        logic [7:0]       bottom;
        for (int i = 0; i < 4; i++) begin
            ch[i] = unpack_channels(tx[i], fmt);
        end
        en  = enable_mask(fmt);
        res = '0;
        for (int c = 0; c < 4; c++) begin
            if (en[c]) begin
                top    = lerp_ref(ch[0][8*c +: 8], ch[1][8*c +: 8], uu);
                bottom = lerp_ref(ch[2][8*c +: 8], ch[3][8*c +: 8], uu);
                res[8*c +: 8] = lerp_ref(top, bottom, vv);
            end
        end
        return res;
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Counts edges from the req edge until rsp_valid is seen; req drops after one edge.
    task automatic wait_response(output int edges);
        logic seen;
        edges = 0;
        seen  = 1'b0;
        while (!seen && edges < RESPONSE_TIMEOUT) begin
            @(posedge clk);
            #1;
            req = 1'b0;
            edges++;
            check_equal(32'(busy), 32'd1, "busy while a request is pending");
            seen = rsp_valid;
        end
        if (!seen) begin
            $display("Timeout: the sampler gave no response within %0d clock cycles", edges);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Response timeout");
        end
    endtask

    task automatic run_request(input logic [2:0] fmt, input logic filt, input logic [7:0] uu,
                               input logic [7:0] vv, input logic [3:0][31:0] tx,
                               output int edges);
        @(posedge clk);
        #1;
        format     = fmt;
        filter     = filt;
        u          = uu;
        v          = vv;
        texel_data = tx;
        req        = 1'b1;
        wait_response(edges);
    endtask

    task automatic test_point_formats();
        logic [3:0][31:0] tx;
        int edges;
        check_equal(32'(busy), 32'd0, "busy after reset");
        check_equal(32'(rsp_valid), 32'd0, "rsp_valid after reset");
        for (int f = 0; f < 6; f++) begin
            tx = random_quad();
            run_request(3'(f), tex_pkg::POINT, 8'd0, 8'd0, tx, edges);
            check_equal(32'(edges), 32'd2, "point latency");
            check_equal(color, point_texel(tx[0], 3'(f)), "point texel");
        end
    endtask

    // With u = v = 0 the blend reduces to texel 0, disabled channels stay zero.
    task automatic test_zero_fraction();
        logic [3:0][31:0] tx;
        logic [31:0] expected;
        logic [3:0]  en;
        int edges;
        for (int f = 0; f < 6; f++) begin
            tx = random_quad();
            expected = unpack_channels(tx[0], 3'(f));
            en = enable_mask(3'(f));
            for (int c = 0; c < 4; c++) begin
                if (!en[c]) begin
                    expected[8*c +: 8] = 8'h00;
                end
            end
            run_request(3'(f), tex_pkg::BILINEAR, 8'd0, 8'd0, tx, edges);
            check_equal(color, expected, "bilinear with zero fractions");
        end
    endtask

    task automatic test_random_bilinear();
        logic [3:0][31:0] tx;
        logic [31:0] r;
        logic [2:0]  fmt;
        int edges;
        for (int n = 0; n < 40; n++) begin
            tx  = random_quad();
            r   = lcg_next();
            fmt = r[30:28];
            run_request(fmt, tex_pkg::BILINEAR, r[23:16], r[15:8], tx, edges);
            check_equal(color, expected_bilinear(tx, fmt, r[23:16], r[15:8]), "random bilinear");
        end
    endtask

    // One UNPACK edge, one edge per enabled channel, one edge into RESPOND.
    task automatic test_bilinear_latency();
        logic [3:0][31:0] tx;
        logic [2:0] fmts [4];
        int edges;
        fmts = '{3'd0, 3'd1, 3'd3, 3'd4};
        foreach (fmts[k]) begin
            tx = random_quad();
            run_request(fmts[k], tex_pkg::BILINEAR, 8'd128, 8'd64, tx, edges);
            check_equal(32'(edges), 32'(2 + $countones(enable_mask(fmts[k]))), "bilinear latency");
        end
    endtask

    task automatic test_busy_ignored();
        logic [3:0][31:0] first_tx;
        logic [31:0] expected;
        int edges;
        first_tx = random_quad();
        expected = expected_bilinear(first_tx, 3'd0, 8'd77, 8'd190);
        @(posedge clk);
        #1;
        format     = 3'd0;
        filter     = tex_pkg::BILINEAR;
        u          = 8'd77;
        v          = 8'd190;
        texel_data = first_tx;
        req        = 1'b1;
        @(posedge clk);
        #1;
        check_equal(32'(busy), 32'd1, "busy after the first request");
        format     = 3'd4;
        filter     = tex_pkg::POINT;
        u          = 8'd3;
        texel_data = random_quad();
        req        = 1'b1;
        wait_response(edges);
        check_equal(32'(edges + 1), 32'd6, "latency with an ignored request");
        check_equal(color, expected, "response to the first request");
        repeat (4) begin
            @(posedge clk);
            #1;
            check_equal(32'(busy), 32'd0, "busy after the response");
            check_equal(32'(rsp_valid), 32'd0, "rsp_valid after the response");
            check_equal(color, expected, "color held after the response");
        end
    endtask

    initial begin
        lcg_state  = 32'd29;
        rst_n      = 1'b0;
        req        = 1'b0;
        format     = '0;
        filter     = 1'b0;
        u          = '0;
        v          = '0;
        texel_data = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_point_formats();
        test_zero_fraction();
        test_random_bilinear();
        test_bilinear_latency();
        test_busy_ignored();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* tex_format/tex_format.sv */
`timescale 1ns/1ps
`include "tex_defs.svh"

module tex_format (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   load,
    input  logic [`TEX_NUM_TEXELS-1:0][31:0]       texel_data,
    input  tex_pkg::tex_format_e                   format,
    input  tex_pkg::tex_filter_e                   filter_in,
    input  logic [`TEX_FRAC_BITS-1:0]              u_in,
    input  logic [`TEX_FRAC_BITS-1:0]              v_in,
    tex_texel_if.fmt                               texels
);

    localparam int LERP_BITS = 2 * `TEX_COLOR_BITS * `TEX_NUM_CHANNELS;
    localparam int SLOT_BITS = 2 * `TEX_COLOR_BITS;

    logic [`TEX_NUM_TEXELS-1:0][`TEX_NUM_CHANNELS-1:0][`TEX_COLOR_BITS-1:0] chans;
    logic [`TEX_NUM_TEXELS-1:0][LERP_BITS-1:0]    lerp_next;
    logic [`TEX_NUM_CHANNELS*`TEX_COLOR_BITS-1:0] pt_next;
    logic [`TEX_NUM_CHANNELS-1:0]                 enable_next;

    // Field extraction, zero extended to a full channel.
    always_comb begin
        for (int i = 0; i < `TEX_NUM_TEXELS; i++) begin
            chans[i] = '0;
            case (format)
                tex_pkg::TEX_FORMAT_R5G6B5: begin
                    chans[i][0] = `TEX_COLOR_BITS'(texel_data[i][4:0]);
                    chans[i][1] = `TEX_COLOR_BITS'(texel_data[i][10:5]);
                    chans[i][2] = `TEX_COLOR_BITS'(texel_data[i][15:11]);
                end
                tex_pkg::TEX_FORMAT_R4G4B4A4: begin
                    chans[i][0] = `TEX_COLOR_BITS'(texel_data[i][3:0]);
                    chans[i][1] = `TEX_COLOR_BITS'(texel_data[i][7:4]);
                    chans[i][2] = `TEX_COLOR_BITS'(texel_data[i][11:8]);
                    chans[i][3] = `TEX_COLOR_BITS'(texel_data[i][15:12]);
                end
                tex_pkg::TEX_FORMAT_L8A8: begin
                    chans[i][0] = texel_data[i][7:0];
                    chans[i][1] = texel_data[i][15:8];
                end
                tex_pkg::TEX_FORMAT_L8,
                tex_pkg::TEX_FORMAT_A8: begin
                    chans[i][0] = texel_data[i][7:0];
                end
                default: begin
                    chans[i] = texel_data[i];
                end
            endcase
        end
    end

    always_comb begin
        case (format)
            tex_pkg::TEX_FORMAT_R5G6B5:   enable_next = 4'b0111;
            tex_pkg::TEX_FORMAT_R4G4B4A4: enable_next = 4'b0111;
            tex_pkg::TEX_FORMAT_L8A8:     enable_next = 4'b0011;
            tex_pkg::TEX_FORMAT_L8:       enable_next = 4'b0001;
            tex_pkg::TEX_FORMAT_A8:       enable_next = 4'b0001;
            default:                      enable_next = 4'b1111;
        endcase
    end

    // Spread each channel into its own 16-bit slot for the blender.
    always_comb begin
        for (int i = 0; i < `TEX_NUM_TEXELS; i++) begin
            for (int c = 0; c < `TEX_NUM_CHANNELS; c++) begin
                lerp_next[i][c*SLOT_BITS +: SLOT_BITS] = SLOT_BITS'(chans[i][c]);
            end
        end
    end

    // R5G6B5 point samples carry an opaque byte below the color.
    always_comb begin
        if (format == tex_pkg::TEX_FORMAT_R5G6B5) begin
            pt_next = {chans[0][2], chans[0][1], chans[0][0], 8'hFF};
        end else begin
            pt_next = chans[0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            texels.color_enable <= '0;
            texels.filter       <= tex_pkg::POINT;
        end else if (load) begin
            texels.color_enable <= enable_next;
            texels.filter       <= filter_in;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            texels.lerp_texel <= lerp_next;
            texels.pt_texel   <= pt_next;
            texels.u          <= u_in;
            texels.v          <= v_in;
        end
    end

endmodule

/* tex_lerp/tex_lerp.sv */
`timescale 1ns/1ps
`include "tex_defs.svh"

module tex_lerp (
    input  logic                                      clk,
    input  logic                                      rst_n,
    tex_texel_if.lerp                                 texels,
    input  logic                                      blend_en,
    input  logic                                      pt_store,
    input  logic                                      clear,
    input  logic [1:0]                                chan,
    output logic [`TEX_NUM_CHANNELS*`TEX_COLOR_BITS-1:0] color
);

    localparam int SLOT_BITS = 2 * `TEX_COLOR_BITS;

    logic [`TEX_NUM_TEXELS-1:0][`TEX_COLOR_BITS-1:0] tap;
    logic [`TEX_COLOR_BITS-1:0]                      top_row;
    logic [`TEX_COLOR_BITS-1:0]                      bottom_row;
    logic [`TEX_COLOR_BITS-1:0]                      blend;

    // (a * (256 - f) + b * f) >> 8 with a 16-bit sum.
    function automatic logic [`TEX_COLOR_BITS-1:0] lerp8(
        input logic [`TEX_COLOR_BITS-1:0] a,
        input logic [`TEX_COLOR_BITS-1:0] b,
        input logic [`TEX_FRAC_BITS-1:0]  f
    );
        logic [15:0] wa;
        logic [15:0] wb;
        logic [15:0] sum;
        wa  = 16'(a) * (16'd256 - 16'(f));
        wb  = 16'(b) * 16'(f);
        sum = wa + wb;
        return sum[15:8];
    endfunction

    // Pick the active channel out of every texel of the quad.
    always_comb begin
        for (int i = 0; i < `TEX_NUM_TEXELS; i++) begin
            tap[i] = texels.lerp_texel[i][chan*SLOT_BITS +: `TEX_COLOR_BITS];
        end
    end

    assign top_row    = lerp8(tap[0], tap[1], texels.u);
    assign bottom_row = lerp8(tap[2], tap[3], texels.u);
    assign blend      = lerp8(top_row, bottom_row, texels.v);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            color <= '0;
        end else if (clear) begin
            color <= '0;
        end else if (pt_store) begin
            color <= texels.pt_texel;
        end else if (blend_en) begin
            color[chan*`TEX_COLOR_BITS +: `TEX_COLOR_BITS] <= blend;
        end
    end

endmodule
